// ==== run_sim.sh ====
#!/bin/sh
# build and run tb_spi_host with verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Mdir obj_dir --top-module tb_spi_host -f spi_host.f \
  && ./obj_dir/Vtb_spi_host > "$LOG" 2>&1 \
  || { echo "run_sim: build or simulation failed"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

grep -q '^\*\*\* PASSED \*\*\*$' "$LOG" \
  && echo "run_sim: test passed" \
  || { echo "run_sim: test failed"; exit 1; }

exit 0

// ==== source/spi_byte_engine.sv ====
// spi byte engine with sck generator, tx/rx shift registers and bit sequencer FSM
`timescale 1ns/1ps

module spi_byte_engine (
  input  logic                               clk,
  input  logic                               reset_n,
  input  spi_host_pkg::spi_cmd_t             cmd,
  input  logic                               spi_miso,
  output spi_host_pkg::spi_pins_t            pins,
  output logic [spi_host_pkg::SPI_BITS-1:0]  rx_data,
  output logic                               ready
);
  import spi_host_pkg::*;

  // --------------------------------------------------------------------------
  // sequencer states
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_POS_FLANK,
    ST_WAIT_POS,
    ST_NEG_FLANK,
    ST_WAIT_NEG,
    ST_NEXT
  } state_t;

  state_t                state_reg;
  state_t                state_next;

  // slave select level set by ctrl writes only
  logic                  ss_reg;

  // spi clock
  logic                  sck_reg;
  logic                  sck_next;

  // transmit shifter with mosi on its msb
  logic [SPI_BITS-1:0]   tx_reg;
  logic [SPI_BITS-1:0]   tx_next;
  logic                  tx_shift;

  // receive shifter
  logic [SPI_BITS-1:0]   rx_reg;
  logic [SPI_BITS-1:0]   rx_next;
  logic                  rx_shift;

  // miso registered once before use
  logic                  miso_sample;

  // half period counter
  logic [SPI_CTR_W-1:0]  half_ctr;
  logic                  half_ctr_rst;
  logic                  half_done;

  // bit counter
  logic [SPI_BIT_W-1:0]  bit_ctr;
  logic                  bit_ctr_rst;
  logic                  bit_ctr_inc;
  logic                  last_bit;

  // byte done level
  logic                  ready_reg;
  logic                  ready_next;

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------
  assign pins.ss   = ss_reg;
  assign pins.sck  = sck_reg;
  assign pins.mosi = tx_reg[SPI_BITS-1];
  assign rx_data   = rx_reg;
  assign ready     = ready_reg;

  // counter terminal values
  assign half_done = (half_ctr == SPI_CTR_W'(SPI_HALF_CYCLES));
  assign last_bit  = (bit_ctr == SPI_BIT_W'(SPI_BITS - 1));

  // --------------------------------------------------------------------------
  // registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ss_reg      <= 1'b1;
      sck_reg     <= 1'b0;
      tx_reg      <= '0;
      rx_reg      <= '0;
      miso_sample <= 1'b0;
      half_ctr    <= '0;
      bit_ctr     <= '0;
      ready_reg   <= 1'b1;
      state_reg   <= ST_IDLE;
    end else begin
      miso_sample <= spi_miso;
      sck_reg     <= sck_next;
      tx_reg      <= tx_next;
      rx_reg      <= rx_next;
      ready_reg   <= ready_next;
      state_reg   <= state_next;

      // active low select so enable high pulls ss down
      if (cmd.enable_vld) begin
        ss_reg <= ~cmd.enable;
      end

      // free running between flanks and cleared on each flank
      if (half_ctr_rst) begin
        half_ctr <= '0;
      end else begin
        half_ctr <= half_ctr + 1'b1;
      end

      if (bit_ctr_rst) begin
        bit_ctr <= '0;
      end else if (bit_ctr_inc) begin
        bit_ctr <= bit_ctr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // tx shifter
  // --------------------------------------------------------------------------
  always_comb begin
    tx_next = tx_reg;
    // shift left after each bit for msb first on the wire
    if (tx_shift) begin
      tx_next = {tx_reg[SPI_BITS-2:0], 1'b0};
    end else if (cmd.tx_data_vld && ready_reg) begin
      // load only between transfers so a write mid byte is dropped
      tx_next = cmd.tx_data;
    end
  end

  // --------------------------------------------------------------------------
  // rx shifter
  // --------------------------------------------------------------------------
  always_comb begin
    rx_next = rx_reg;
    // zero from the same edge that raises ss and for as long as it stays high
    if (ss_reg || (cmd.enable_vld && !cmd.enable)) begin
      rx_next = '0;
    end else if (rx_shift) begin
      // sample taken the cycle before sck rises holds the bit the
      // slave launched on the previous falling edge
      rx_next = {rx_reg[SPI_BITS-2:0], miso_sample};
    end
  end

  // --------------------------------------------------------------------------
  // bit sequencer
  // --------------------------------------------------------------------------
  always_comb begin
    state_next   = state_reg;
    sck_next     = sck_reg;
    ready_next   = ready_reg;
    tx_shift     = 1'b0;
    rx_shift     = 1'b0;
    half_ctr_rst = 1'b0;
    bit_ctr_rst  = 1'b0;
    bit_ctr_inc  = 1'b0;

    case (state_reg)
      ST_IDLE: begin
        // start ignored anywhere but here
        if (cmd.start) begin
          sck_next    = 1'b0;
          bit_ctr_rst = 1'b1;
          ready_next  = 1'b0;
          state_next  = ST_POS_FLANK;
        end
      end

      ST_POS_FLANK: begin
        // capture then raise sck
        rx_shift     = 1'b1;
        sck_next     = 1'b1;
        half_ctr_rst = 1'b1;
        state_next   = ST_WAIT_POS;
      end

      ST_WAIT_POS: begin
        if (half_done) begin
          state_next = ST_NEG_FLANK;
        end
      end

      ST_NEG_FLANK: begin
        sck_next     = 1'b0;
        half_ctr_rst = 1'b1;
        state_next   = ST_WAIT_NEG;
      end

      ST_WAIT_NEG: begin
        if (half_done) begin
          state_next = ST_NEXT;
        end
      end

      ST_NEXT: begin
        if (last_bit) begin
          // byte done with sck already low
          ready_next = 1'b1;
          state_next = ST_IDLE;
        end else begin
          // present next mosi bit while sck is low
          tx_shift    = 1'b1;
          bit_ctr_inc = 1'b1;
          state_next  = ST_POS_FLANK;
        end
      end

      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

endmodule

// ==== source/spi_host_pkg.sv ====
// spi host package with spi timing constants, register map and bus/pin structs
package spi_host_pkg;

  // --------------------------------------------------------------------------
  // spi timing
  // --------------------------------------------------------------------------
  // terminal count of the half period counter, each sck phase waits one more
  localparam int SPI_HALF_CYCLES = 1;
  // bits moved per start command
  localparam int SPI_BITS = 8;
  // counter widths derived from the above
  localparam int SPI_CTR_W = $clog2(SPI_HALF_CYCLES + 2);
  localparam int SPI_BIT_W = $clog2(SPI_BITS);

  // --------------------------------------------------------------------------
  // register map
  // --------------------------------------------------------------------------
  localparam int REG_ADDR_W = 3;

  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL   = 3'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_TXDATA = 3'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_START  = 3'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 3'd3;
  localparam logic [REG_ADDR_W-1:0] ADDR_RXDATA = 3'd4;

  // enable in ctrl selects the slave
  localparam int CTRL_ENABLE_BIT  = 0;
  // byte done flag
  localparam int STATUS_READY_BIT = 0;

  // host side request, write when cs and we both high
  typedef struct packed {
    logic                  cs;
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
  } host_req_t;

  // single cycle strobes from the register block to the engine
  typedef struct packed {
    logic                enable;
    logic                enable_vld;
    logic                start;
    logic [SPI_BITS-1:0] tx_data;
    logic                tx_data_vld;
  } spi_cmd_t;

  // master driven spi pins
  typedef struct packed {
    logic ss;
    logic sck;
    logic mosi;
  } spi_pins_t;

endpackage

// ==== source/spi_host_regs.sv ====
// spi host register block with write decode, command strobes and registered read mux
`timescale 1ns/1ps

module spi_host_regs (
  input  logic                               clk,
  input  logic                               reset_n,
  input  spi_host_pkg::host_req_t            req,
  output logic [7:0]                         rdata,
  output spi_host_pkg::spi_cmd_t             cmd,
  input  logic [spi_host_pkg::SPI_BITS-1:0]  rx_data,
  input  logic                               ready
);
  import spi_host_pkg::*;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------
  logic                 wr_en;
  logic                 rd_en;
  logic                 wr_ctrl;
  logic                 wr_txdata;
  logic                 wr_start;

  // command state
  logic                 enable_reg;
  logic                 enable_vld_reg;
  logic                 start_reg;
  logic [SPI_BITS-1:0]  tx_data_reg;
  logic                 tx_data_vld_reg;

  // read side
  logic [7:0]           ctrl_val;
  logic [7:0]           status_val;
  logic [7:0]           rd_mux;

  assign wr_en     = req.cs && req.we;
  assign rd_en     = req.cs && !req.we;
  assign wr_ctrl   = wr_en && (req.addr == ADDR_CTRL);
  assign wr_txdata = wr_en && (req.addr == ADDR_TXDATA);
  assign wr_start  = wr_en && (req.addr == ADDR_START);

  // --------------------------------------------------------------------------
  // command strobes, one cycle after the write
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      enable_reg      <= 1'b0;
      enable_vld_reg  <= 1'b0;
      start_reg       <= 1'b0;
      tx_data_vld_reg <= 1'b0;
    end else begin
      enable_vld_reg  <= wr_ctrl;
      start_reg       <= wr_start;
      tx_data_vld_reg <= wr_txdata;
      // level kept for ctrl readback, also feeds the engine
      if (wr_ctrl) begin
        enable_reg <= req.wdata[CTRL_ENABLE_BIT];
      end
    end
  end

  // tx byte payload, qualified by tx_data_vld
  always_ff @(posedge clk) begin
    if (wr_txdata) begin
      tx_data_reg <= req.wdata;
    end
  end

  assign cmd.enable      = enable_reg;
  assign cmd.enable_vld  = enable_vld_reg;
  assign cmd.start       = start_reg;
  assign cmd.tx_data     = tx_data_reg;
  assign cmd.tx_data_vld = tx_data_vld_reg;

  // --------------------------------------------------------------------------
  // read back
  // --------------------------------------------------------------------------
  always_comb begin
    ctrl_val                   = '0;
    ctrl_val[CTRL_ENABLE_BIT]  = enable_reg;
    status_val                 = '0;
    status_val[STATUS_READY_BIT] = ready;

    case (req.addr)
      ADDR_CTRL:   rd_mux = ctrl_val;
      ADDR_STATUS: rd_mux = status_val;
      ADDR_RXDATA: rd_mux = rx_data;
      // txdata and start are write only
      default:     rd_mux = '0;
    endcase
  end

  // rdata holds until the next read
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rdata <= '0;
    end else if (rd_en) begin
      rdata <= rd_mux;
    end
  end

endmodule

// ==== source/spi_host_top.sv ====
// spi host top level joining the register block and the byte engine
`timescale 1ns/1ps

module spi_host_top (
  input  logic                     clk,
  input  logic                     reset_n,
  // host register bus
  input  spi_host_pkg::host_req_t  req,
  output logic [7:0]               rdata,
  // flash side
  output spi_host_pkg::spi_pins_t  spi_pins,
  input  logic                     spi_miso
);
  import spi_host_pkg::*;

  // --------------------------------------------------------------------------
  // internal wires
  // --------------------------------------------------------------------------
  // strobes from regs to engine
  spi_cmd_t             cmd;
  // engine status back to regs
  logic [SPI_BITS-1:0]  rx_data;
  logic                 ready;

  // --------------------------------------------------------------------------
  // register block
  // --------------------------------------------------------------------------
  spi_host_regs i_regs (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (req),
    .rdata   (rdata),
    .cmd     (cmd),
    .rx_data (rx_data),
    .ready   (ready)
  );

  // --------------------------------------------------------------------------
  // byte engine
  // --------------------------------------------------------------------------
  spi_byte_engine i_engine (
    .clk      (clk),
    .reset_n  (reset_n),
    .cmd      (cmd),
    .spi_miso (spi_miso),
    .pins     (spi_pins),
    .rx_data  (rx_data),
    .ready    (ready)
  );

endmodule

// ==== spi_host.f ====
source/spi_host_pkg.sv
source/spi_byte_engine.sv
source/spi_host_regs.sv
source/spi_host_top.sv
tb/spi_flash_model.sv
tb/tb_spi_host.sv

// ==== tb/spi_flash_model.sv ====
// behavioral spi flash slave that answers each byte with its inverse, flash style alignment
`timescale 1ns/1ps

module spi_flash_model (
  input  spi_host_pkg::spi_pins_t  pins,
  output logic                     miso
);
  import spi_host_pkg::*;

  logic                 ss;
  logic                 sck;
  logic                 mosi;

  // receive side, bit_cnt runs 1..8 within a byte
  logic [SPI_BITS-1:0]  shift_in = '0;
  int                   bit_cnt = 0;
  // response shifter, msb is on miso
  logic [SPI_BITS-1:0]  shift_out = '0;
  // observed by the testbench
  logic [SPI_BITS-1:0]  last_byte = '0;
  int                   byte_count = 0;

  assign ss   = pins.ss;
  assign sck  = pins.sck;
  assign mosi = pins.mosi;

  // mode 0, mosi sampled on rising sck
  always @(posedge sck or posedge ss) begin
    if (ss) begin
      shift_in <= '0;
      bit_cnt  <= 0;
    end else begin
      shift_in <= {shift_in[SPI_BITS-2:0], mosi};
      bit_cnt  <= (bit_cnt == SPI_BITS) ? 1 : bit_cnt + 1;
      // eighth bit completes the byte
      if (bit_cnt == SPI_BITS - 1) begin
        last_byte  <= {shift_in[SPI_BITS-2:0], mosi};
        byte_count <= byte_count + 1;
      end
    end
  end

  // response msb launched on the falling edge that ends the byte
  always @(negedge sck or posedge ss) begin
    if (ss) begin
      shift_out <= '0;
      miso      <= 1'b0;
    end else if (bit_cnt == SPI_BITS) begin
      shift_out <= ~shift_in;
      miso      <= ~shift_in[SPI_BITS-1];
    end else begin
      shift_out <= {shift_out[SPI_BITS-2:0], 1'b0};
      miso      <= shift_out[SPI_BITS-2];
    end
  end

endmodule

// ==== tb/tb_spi_host.sv ====
// testbench for spi_host_top with flash model, host bus tasks, checks, timeout and verdict
`timescale 1ns/1ps

module tb_spi_host;
  import spi_host_pkg::*;

  // ---------------------------------------------------------------------------
  // run length of 12 bytes at 8 cycles a bit plus margin
  // ---------------------------------------------------------------------------
  localparam int MAX_XFERS  = 12;
  localparam int BIT_CYCLES = 2 * (SPI_HALF_CYCLES + 1) + 4;
  localparam int MAX_CYCLES = MAX_XFERS * SPI_BITS * BIT_CYCLES + 500;

  logic        clk = 1'b0;
  logic        reset_n;
  host_req_t   req;
  logic [7:0]  rdata;
  spi_pins_t   spi_pins;
  logic        spi_miso;

  int          cycle_cnt = 0;
  integer      seed;
  logic [31:0] rnd;
  logic [7:0]  rd_val;
  logic [7:0]  tx_byte;
  // reference state for the response rule
  logic [7:0]  prev_tx;
  logic        first_in_select;
  int          xfer_count;

  spi_host_top i_dut (.clk(clk), .reset_n(reset_n), .req(req), .rdata(rdata),
                      .spi_pins(spi_pins), .spi_miso(spi_miso));

  spi_flash_model i_flash (.pins(spi_pins), .miso(spi_miso));

  always #5 clk = ~clk;

  // hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout, test sequence still running after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  // ---------------------------------------------------------------------------
  // checks and host bus tasks
  // ---------------------------------------------------------------------------
  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    assert (actual === expected)
    else begin
      $display("[ERROR] %0d ns %s expected 0x%02h actual 0x%02h", $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input logic [REG_ADDR_W-1:0] addr, input logic [7:0] data);
    host_req_t wr;
    wr = '{cs: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge clk);
    req <= wr;
    @(posedge clk);
    req <= '0;
  endtask

  // rdata is taken one cycle after the request
  task automatic bus_read(input logic [REG_ADDR_W-1:0] addr, output logic [7:0] data);
    host_req_t rd;
    rd = '{cs: 1'b1, we: 1'b0, addr: addr, wdata: 8'h00};
    @(posedge clk);
    req <= rd;
    @(posedge clk);
    req <= '0;
    @(posedge clk);
    data = rdata;
  endtask

  task automatic wait_ready();
    logic [7:0] status;
    status = '0;
    while (!status[STATUS_READY_BIT]) begin
      bus_read(ADDR_STATUS, status);
    end
  endtask

  // load, start, and see the engine busy
  task automatic start_byte(input logic [7:0] tx);
    logic [7:0] status;
    bus_write(ADDR_TXDATA, tx);
    bus_write(ADDR_START, 8'h00);
    bus_read(ADDR_STATUS, status);
    check_byte("status.ready", 8'h00, {7'b0, status[STATUS_READY_BIT]});
  endtask

  // rx must be the inverse of the previous tx or zero for the first in a select
  task automatic finish_byte(input logic [7:0] tx);
    logic [7:0] rx;
    logic [7:0] expected;
    wait_ready();
    bus_read(ADDR_RXDATA, rx);
    expected = first_in_select ? 8'h00 : ~prev_tx;
    check_byte("rxdata", expected, rx);
    xfer_count = xfer_count + 1;
    check_byte("flash.last_byte", tx, i_flash.last_byte);
    check_byte("flash.byte_count", 8'(xfer_count), 8'(i_flash.byte_count));
    prev_tx = tx;
    first_in_select = 1'b0;
  endtask

  task automatic random_transfer();
    rnd = $random(seed);
    tx_byte = rnd[7:0];
    start_byte(tx_byte);
    finish_byte(tx_byte);
  endtask

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  initial begin
    reset_n <= 1'b0;
    req <= '0;
    seed = 88105;
    prev_tx = 8'h00;
    first_in_select = 1'b1;
    xfer_count = 0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    // idle state out of reset
    bus_read(ADDR_STATUS, rd_val);
    check_byte("status.ready", 8'h01, {7'b0, rd_val[STATUS_READY_BIT]});
    bus_read(ADDR_RXDATA, rd_val);
    check_byte("rxdata", 8'h00, rd_val);
    check_byte("spi_pins.ss", 8'h01, {7'b0, spi_pins.ss});
    check_byte("spi_pins.sck", 8'h00, {7'b0, spi_pins.sck});

    // select on, readback, select off
    bus_write(ADDR_CTRL, 8'h01);
    bus_read(ADDR_CTRL, rd_val);
    check_byte("ctrl", 8'h01, rd_val);
    check_byte("spi_pins.ss", 8'h00, {7'b0, spi_pins.ss});
    bus_write(ADDR_CTRL, 8'h00);
    bus_read(ADDR_RXDATA, rd_val);
    check_byte("rxdata", 8'h00, rd_val);
    check_byte("spi_pins.ss", 8'h01, {7'b0, spi_pins.ss});

    // random bytes within one select
    bus_write(ADDR_CTRL, 8'h01);
    first_in_select = 1'b1;
    for (int i = 0; i < 6; i++) begin
      random_transfer();
    end

    // txdata and start mid transfer are dropped
    rnd = $random(seed);
    tx_byte = rnd[7:0];
    start_byte(tx_byte);
    bus_write(ADDR_TXDATA, ~tx_byte);
    bus_write(ADDR_START, 8'h00);
    finish_byte(tx_byte);
    bus_read(ADDR_STATUS, rd_val);
    check_byte("status.ready", 8'h01, {7'b0, rd_val[STATUS_READY_BIT]});
    repeat (SPI_BITS * BIT_CYCLES) @(posedge clk);
    check_byte("flash.byte_count", 8'(xfer_count), 8'(i_flash.byte_count));
    random_transfer();

    // deselect clears rx and reselect restarts alignment
    bus_write(ADDR_CTRL, 8'h00);
    bus_read(ADDR_RXDATA, rd_val);
    check_byte("rxdata", 8'h00, rd_val);
    bus_write(ADDR_CTRL, 8'h01);
    first_in_select = 1'b1;
    random_transfer();
    random_transfer();

    $display("*** PASSED ***");
    $finish;
  end

endmodule
